//--- verilog/soc_bus_consts.svh
// ################################################
// SoC bus constants
// Port counts, field widths, credit depth, address map
// ################################################

`ifndef SOC_BUS_CONSTS_SVH
`define SOC_BUS_CONSTS_SVH

// Port counts and target indices
`define SOC_N_CLUSTERS   2
`define SOC_L2_N_PORTS   2
`define SOC_N_INIT       3
`define SOC_N_TGT        5
`define SOC_IDX_L2       2
`define SOC_IDX_HOST     4

// Field widths in bits
`define SOC_ADDR_W       32
`define SOC_DATA_W       32
`define SOC_ID_IN_W      4
`define SOC_INIT_IDX_W   2
`define SOC_ID_OUT_W     (`SOC_ID_IN_W + `SOC_INIT_IDX_W)
`define SOC_TGT_IDX_W    3
`define SOC_CNT_W        3

// Ingress depth, also the initial target credit count
`define SOC_CREDITS      4

// Address map
`define SOC_CL_BASE      32'h1000_0000
`define SOC_CL_STRIDE    32'h0040_0000
`define SOC_CL_SIZE      32'h0030_0000
`define SOC_PERIPH_BASE  32'h1A00_0000
`define SOC_PERIPH_BYTES 32'h0100_0000
`define SOC_L2_BASE      32'h1C00_0000
`define SOC_L2_BYTES     32'h0001_0000

`endif

//--- verilog/soc_bus_pkg.sv
// ################################################
// SoC bus types
// Vector types shared by the bus and its testbench
// ################################################

`include "soc_bus_consts.svh"

package soc_bus_pkg;

  // Request payload
  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;

  // ID as issued by an initiator
  typedef logic [`SOC_ID_IN_W-1:0] id_in_t;

  // Source index on top, original ID below
  typedef logic [`SOC_ID_OUT_W-1:0] id_out_t;

  // Port indices
  typedef logic [`SOC_INIT_IDX_W-1:0] init_idx_t;
  typedef logic [`SOC_TGT_IDX_W-1:0] tgt_idx_t;

  // Holds 0 up to SOC_CREDITS
  typedef logic [`SOC_CNT_W-1:0] credit_cnt_t;

endpackage

//--- verilog/soc_bus_if.sv
// ################################################
// SoC bus internal interfaces
// Ingress to switch and switch to egress
// ################################################

`timescale 1ns/1ns

// Head of one ingress buffer, decoded
interface soc_bus_req_if;
  import soc_bus_pkg::*;

  logic     valid;
  tgt_idx_t tgt;
  addr_t    addr;
  data_t    data;
  id_in_t   id;
  // Entry leaves the buffer when valid and pop are high
  logic     pop;

  modport src (output valid, tgt, addr, data, id, input pop);
  modport dst (input valid, tgt, addr, data, id, output pop);

endinterface

// Granted item for one target
interface soc_bus_tgt_if;
  import soc_bus_pkg::*;

  logic    valid;
  addr_t   addr;
  data_t   data;
  id_out_t id_out;
  // Egress still holds at least one target credit
  logic    has_credit;

  modport src (output valid, addr, data, id_out, input has_credit);
  modport dst (input valid, addr, data, id_out, output has_credit);

endinterface

//--- verilog/soc_bus_ingress.sv
// ################################################
// SoC bus ingress
// Per-initiator request buffer, address decode and
// credit return
// ################################################

`timescale 1ns/1ns
`include "soc_bus_consts.svh"

module soc_bus_ingress (
  input  logic                clk_i,
  input  logic                arst_n,
  input  logic                valid,
  input  soc_bus_pkg::addr_t  addr,
  input  soc_bus_pkg::data_t  data,
  input  soc_bus_pkg::id_in_t id,
  output logic                credit,
  output logic                decode_err,
  soc_bus_req_if.src          req
);
  import soc_bus_pkg::*;

  localparam int unsigned ptr_w = $clog2(`SOC_CREDITS);

  addr_t             buf_addr [`SOC_CREDITS];
  data_t             buf_data [`SOC_CREDITS];
  id_in_t            buf_id   [`SOC_CREDITS];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  credit_cnt_t       fill;
  addr_t             head_addr;
  logic              head_present;
  logic              hit;
  tgt_idx_t          dec_tgt;
  logic              drop;
  logic              free;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(`SOC_CREDITS - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  function automatic addr_t cl_base(input int unsigned i);
    return addr_t'(`SOC_CL_BASE + i * `SOC_CL_STRIDE);
  endfunction

  function automatic addr_t l2_base(input int unsigned i);
    return addr_t'(`SOC_L2_BASE + i * `SOC_L2_BYTES);
  endfunction

  assign head_present = (fill != '0);
  assign head_addr    = buf_addr[rd_ptr];

  // First matching rule wins, host is the catch-all target
  always_comb begin
    hit     = 1'b0;
    dec_tgt = tgt_idx_t'(`SOC_IDX_HOST);
    if (head_addr < addr_t'(`SOC_CL_BASE)) begin
      hit = 1'b1;
    end
    for (int unsigned i = 0; i < `SOC_N_CLUSTERS; i++) begin
      if (!hit && head_addr >= cl_base(i) &&
          head_addr < cl_base(i) + addr_t'(`SOC_CL_SIZE)) begin
        hit     = 1'b1;
        dec_tgt = tgt_idx_t'(i);
      end
    end
    // Peripheral window goes to the host
    if (!hit && head_addr >= addr_t'(`SOC_PERIPH_BASE) &&
        head_addr < addr_t'(`SOC_PERIPH_BASE + `SOC_PERIPH_BYTES)) begin
      hit = 1'b1;
    end
    for (int unsigned i = 0; i < `SOC_L2_N_PORTS; i++) begin
      if (!hit && head_addr >= l2_base(i) && head_addr < l2_base(i + 1)) begin
        hit     = 1'b1;
        dec_tgt = tgt_idx_t'(`SOC_IDX_L2 + i);
      end
    end
    if (!hit && head_addr >= l2_base(`SOC_L2_N_PORTS)) begin
      hit = 1'b1;
    end
  end

  assign req.valid = head_present & hit;
  assign req.tgt   = dec_tgt;
  assign req.addr  = head_addr;
  assign req.data  = buf_data[rd_ptr];
  assign req.id    = buf_id[rd_ptr];

  // Unmapped heads leave without waiting for the switch
  assign drop = head_present & ~hit;
  assign free = (req.valid & req.pop) | drop;

  always_ff @(posedge clk_i) begin
    if (valid) begin
      buf_addr[wr_ptr] <= addr;
      buf_data[wr_ptr] <= data;
      buf_id[wr_ptr]   <= id;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      credit     <= 1'b0;
      decode_err <= 1'b0;
    end else begin
      if (valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (free) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      fill       <= fill + credit_cnt_t'(valid) - credit_cnt_t'(free);
      credit     <= free;
      decode_err <= drop;
    end
  end

endmodule

//--- verilog/soc_bus_switch.sv
// ################################################
// SoC bus switch
// Round-robin grant per target, source index
// added above the request ID
// ################################################

`timescale 1ns/1ns
`include "soc_bus_consts.svh"

module soc_bus_switch (
  input  logic       clk_i,
  input  logic       arst_n,
  soc_bus_req_if.dst req [`SOC_N_INIT],
  soc_bus_tgt_if.src tgt [`SOC_N_TGT]
);
  import soc_bus_pkg::*;

  logic [`SOC_N_INIT-1:0] req_valid;
  tgt_idx_t               req_tgt  [`SOC_N_INIT];
  addr_t                  req_addr [`SOC_N_INIT];
  data_t                  req_data [`SOC_N_INIT];
  id_in_t                 req_id   [`SOC_N_INIT];
  logic [`SOC_N_INIT-1:0] pop;

  logic [`SOC_N_TGT-1:0]  has_credit;
  logic [`SOC_N_TGT-1:0]  gnt;
  init_idx_t              winner   [`SOC_N_TGT];
  init_idx_t              rr_ptr   [`SOC_N_TGT];

  // Flatten interface arrays for indexed access
  for (genvar i = 0; i < `SOC_N_INIT; i++) begin : gen_req
    assign req_valid[i] = req[i].valid;
    assign req_tgt[i]   = req[i].tgt;
    assign req_addr[i]  = req[i].addr;
    assign req_data[i]  = req[i].data;
    assign req_id[i]    = req[i].id;
    assign req[i].pop   = pop[i];
  end

  for (genvar t = 0; t < `SOC_N_TGT; t++) begin : gen_tgt
    assign has_credit[t]   = tgt[t].has_credit;
    assign tgt[t].valid    = gnt[t];
    assign tgt[t].addr     = req_addr[winner[t]];
    assign tgt[t].data     = req_data[winner[t]];
    // Source index goes in the upper bits
    assign tgt[t].id_out   = {winner[t], req_id[winner[t]]};
  end

  always_comb begin
    int unsigned cand;
    gnt = '0;
    pop = '0;
    for (int unsigned t = 0; t < `SOC_N_TGT; t++) begin
      winner[t] = rr_ptr[t];
      // Search starts at the pointer and wraps
      for (int unsigned k = 0; k < `SOC_N_INIT; k++) begin
        cand = rr_ptr[t] + k;
        if (cand >= `SOC_N_INIT) begin
          cand = cand - `SOC_N_INIT;
        end
        if (!gnt[t] && has_credit[t] && req_valid[cand] &&
            req_tgt[cand] == tgt_idx_t'(t)) begin
          gnt[t]    = 1'b1;
          winner[t] = init_idx_t'(cand);
        end
      end
    end
    // A head names one target, so at most one grant per initiator
    for (int unsigned t = 0; t < `SOC_N_TGT; t++) begin
      if (gnt[t]) begin
        pop[winner[t]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      for (int unsigned t = 0; t < `SOC_N_TGT; t++) begin
        rr_ptr[t] <= '0;
      end
    end else begin
      for (int unsigned t = 0; t < `SOC_N_TGT; t++) begin
        if (gnt[t]) begin
          // Move past the winner
          if (winner[t] == init_idx_t'(`SOC_N_INIT - 1)) begin
            rr_ptr[t] <= '0;
          end else begin
            rr_ptr[t] <= winner[t] + 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- verilog/soc_bus_egress.sv
// ################################################
// SoC bus egress
// Target credit counters and registered outputs
// ################################################

`timescale 1ns/1ns
`include "soc_bus_consts.svh"

module soc_bus_egress (
  input  logic                                    clk_i,
  input  logic                                    arst_n,
  soc_bus_tgt_if.dst                              tgt [`SOC_N_TGT],
  output logic [`SOC_N_TGT-1:0]                   tgt_valid,
  output soc_bus_pkg::addr_t [`SOC_N_TGT-1:0]     tgt_addr,
  output soc_bus_pkg::data_t [`SOC_N_TGT-1:0]     tgt_data,
  output soc_bus_pkg::id_out_t [`SOC_N_TGT-1:0]   tgt_id,
  input  logic [`SOC_N_TGT-1:0]                   tgt_credit
);
  import soc_bus_pkg::*;

  credit_cnt_t credits [`SOC_N_TGT];

  for (genvar t = 0; t < `SOC_N_TGT; t++) begin : gen_port
    // Switch only grants while this is high
    assign tgt[t].has_credit = (credits[t] != '0);

    always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
        credits[t]   <= credit_cnt_t'(`SOC_CREDITS);
        tgt_valid[t] <= 1'b0;
      end else begin
        // One spent per item sent, one back per returned pulse
        credits[t]   <= credits[t] - credit_cnt_t'(tgt[t].valid)
                        + credit_cnt_t'(tgt_credit[t]);
        tgt_valid[t] <= tgt[t].valid;
      end
    end

    // Payload loads only with a grant
    always_ff @(posedge clk_i) begin
      if (tgt[t].valid) begin
        tgt_addr[t] <= tgt[t].addr;
        tgt_data[t] <= tgt[t].data;
        tgt_id[t]   <= tgt[t].id_out;
      end
    end
  end

endmodule

//--- verilog/soc_bus.sv
// ################################################
// SoC bus top level
// Three initiators routed to five targets with
// credit flow control on both sides
// ################################################

`timescale 1ns/1ns
`include "soc_bus_consts.svh"

module soc_bus (
  input  logic                                    clk_i,
  input  logic                                    arst_n,
  // Initiator side, cluster 0, cluster 1, host
  input  logic [`SOC_N_INIT-1:0]                  init_valid,
  input  soc_bus_pkg::addr_t [`SOC_N_INIT-1:0]    init_addr,
  input  soc_bus_pkg::data_t [`SOC_N_INIT-1:0]    init_data,
  input  soc_bus_pkg::id_in_t [`SOC_N_INIT-1:0]   init_id,
  output logic [`SOC_N_INIT-1:0]                  init_credit,
  output logic [`SOC_N_INIT-1:0]                  decode_err,
  // Target side, clusters, L2 ports, host
  output logic [`SOC_N_TGT-1:0]                   tgt_valid,
  output soc_bus_pkg::addr_t [`SOC_N_TGT-1:0]     tgt_addr,
  output soc_bus_pkg::data_t [`SOC_N_TGT-1:0]     tgt_data,
  output soc_bus_pkg::id_out_t [`SOC_N_TGT-1:0]   tgt_id,
  input  logic [`SOC_N_TGT-1:0]                   tgt_credit
);

  soc_bus_req_if req_bus [`SOC_N_INIT] ();
  soc_bus_tgt_if tgt_bus [`SOC_N_TGT] ();

  for (genvar k = 0; k < `SOC_N_INIT; k++) begin : gen_ingress
    soc_bus_ingress i_ingress (
      .clk_i      (clk_i),
      .arst_n     (arst_n),
      .valid      (init_valid[k]),
      .addr       (init_addr[k]),
      .data       (init_data[k]),
      .id         (init_id[k]),
      .credit     (init_credit[k]),
      .decode_err (decode_err[k]),
      .req        (req_bus[k])
    );
  end

  soc_bus_switch i_switch (
    .clk_i  (clk_i),
    .arst_n (arst_n),
    .req    (req_bus),
    .tgt    (tgt_bus)
  );

  soc_bus_egress i_egress (
    .clk_i      (clk_i),
    .arst_n     (arst_n),
    .tgt        (tgt_bus),
    .tgt_valid  (tgt_valid),
    .tgt_addr   (tgt_addr),
    .tgt_data   (tgt_data),
    .tgt_id     (tgt_id),
    .tgt_credit (tgt_credit)
  );

endmodule

//--- verif/soc_bus_assert.sv
// ################################################
// SoC bus assertions
// Target credit limit and initiator pulse rules
// ################################################

`timescale 1ns/1ns
`include "soc_bus_consts.svh"

module soc_bus_assert (
  input logic                   clk_i,
  input logic                   arst_n,
  input logic [`SOC_N_INIT-1:0] init_credit,
  input logic [`SOC_N_INIT-1:0] decode_err,
  input logic [`SOC_N_TGT-1:0]  tgt_valid,
  input logic [`SOC_N_TGT-1:0]  tgt_credit
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  for (genvar t = 0; t < `SOC_N_TGT; t++) begin : gen_tgt
    // Items presented and not yet returned
    int outstanding;

    always_ff @(posedge clk_i or negedge arst_n) begin
      if (!arst_n) begin
        outstanding <= 0;
      end else begin
        outstanding <= outstanding + int'(tgt_valid[t]) - int'(tgt_credit[t]);
      end
    end

    a_credit_limit: assert property (@(posedge clk_i) disable iff (!arst_n)
      tgt_valid[t] |-> outstanding < `SOC_CREDITS)
      else begin
        $error("target %0d received an item without a credit", t);
        fail_count++;
      end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n |-> (init_credit == '0 && decode_err == '0 && tgt_valid == '0))
    else begin
      $error("bus outputs active during reset");
      fail_count++;
    end

  a_err_with_credit: assert property (@(posedge clk_i) disable iff (!arst_n)
    (decode_err & ~init_credit) == '0)
    else begin
      $error("decode error pulse without a returned credit");
      fail_count++;
    end

endmodule

//--- verif/soc_bus_tb.sv
// ################################################
// SoC bus testbench
// Random posted traffic checked against an
// address-map model with per-pair order queues
// ################################################

`timescale 1ns/1ns
`include "soc_bus_consts.svh"

module soc_bus_tb;
  import soc_bus_pkg::*;

  localparam int num_req      = 400;
  localparam int send_timeout = 20000;
  localparam int drain_limit  = 2000;

  typedef struct packed {
    addr_t   addr;
    data_t   data;
    id_out_t id;
  } item_t;

  logic                     clk_i = 1'b0;
  logic                     arst_n;
  logic [`SOC_N_INIT-1:0]   init_valid;
  addr_t [`SOC_N_INIT-1:0]  init_addr;
  data_t [`SOC_N_INIT-1:0]  init_data;
  id_in_t [`SOC_N_INIT-1:0] init_id;
  logic [`SOC_N_INIT-1:0]   init_credit;
  logic [`SOC_N_INIT-1:0]   decode_err;
  logic [`SOC_N_TGT-1:0]    tgt_valid;
  addr_t [`SOC_N_TGT-1:0]   tgt_addr;
  data_t [`SOC_N_TGT-1:0]   tgt_data;
  id_out_t [`SOC_N_TGT-1:0] tgt_id;
  logic [`SOC_N_TGT-1:0]    tgt_credit;

  // Expected items indexed by target * N_INIT + initiator
  item_t exp_q [`SOC_N_TGT * `SOC_N_INIT][$];
  int    init_cred [`SOC_N_INIT];
  int    err_pend  [`SOC_N_INIT];
  int    owed      [`SOC_N_TGT];
  int    delay     [`SOC_N_TGT];
  int    sent;

  soc_bus UUT (.*);

  bind soc_bus soc_bus_assert i_assert (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string what);
    abort_run($sformatf("FAILED at %0t ns: %s", $time, what));
  endtask

  // Bound assertions count their failures
  always @(UUT.i_assert.fail_count) begin
    if (UUT.i_assert.fail_count != 0) abort_run("A bus assertion failed");
  end

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s addr %h, expected %h", what, got, exp));
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s data %h, expected %h", what, got, exp));
  endtask

  task automatic check_id(input id_out_t got, input id_out_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s id %h, expected %h", what, got, exp));
  endtask

  task automatic check_count(input credit_cnt_t got, input credit_cnt_t exp, input string what);
    if (got !== exp) report_mismatch($sformatf("%s count %0d, expected %0d", what, got, exp));
  endtask

  // Target index by the first matching rule or -1 for a gap
  function automatic int map_addr(input addr_t a);
    if (a < 32'h1000_0000) return `SOC_IDX_HOST;
    for (int unsigned i = 0; i < `SOC_N_CLUSTERS; i++) begin
      if (a >= `SOC_CL_BASE + i * `SOC_CL_STRIDE &&
          a < `SOC_CL_BASE + i * `SOC_CL_STRIDE + `SOC_CL_SIZE) return i;
    end
    if (a >= 32'h1A00_0000 && a <= 32'h1AFF_FFFF) return `SOC_IDX_HOST;
    for (int unsigned i = 0; i < `SOC_L2_N_PORTS; i++) begin
      if (a >= `SOC_L2_BASE + i * `SOC_L2_BYTES &&
          a < `SOC_L2_BASE + (i + 1) * `SOC_L2_BYTES) return `SOC_IDX_L2 + i;
    end
    if (a >= `SOC_L2_BASE + 2 * `SOC_L2_BYTES) return `SOC_IDX_HOST;
    return -1;
  endfunction

  // Mostly mapped windows with one case in four in a gap
  function automatic addr_t pick_addr();
    int unsigned sel;
    int unsigned i;
    sel = $urandom % 12;
    i   = $urandom % 2;
    case (sel)
      0:       return $urandom % 32'h1000_0000;
      1, 2, 3: return `SOC_CL_BASE + i * `SOC_CL_STRIDE + $urandom % `SOC_CL_SIZE;
      4:       return 32'h1A00_0000 + $urandom % 32'h0100_0000;
      5, 6, 7: return `SOC_L2_BASE + i * `SOC_L2_BYTES + $urandom % `SOC_L2_BYTES;
      8:       return `SOC_L2_BASE + 2 * `SOC_L2_BYTES + $urandom % 32'h1000_0000;
      9:       return `SOC_CL_BASE + i * `SOC_CL_STRIDE + `SOC_CL_SIZE + $urandom % 32'h0010_0000;
      10:      return 32'h1080_0000 + $urandom % 32'h0980_0000;
      default: return 32'h1B00_0000 + $urandom % 32'h0100_0000;
    endcase
  endfunction

  // One clock edge of target models, scoreboard and initiators
  task automatic step_cycle();
    int    k;
    int    tgt;
    item_t exp;
    for (int t = 0; t < `SOC_N_TGT; t++) begin
      if (tgt_valid[t]) begin
        k = int'(tgt_id[t][`SOC_ID_OUT_W-1 -: `SOC_INIT_IDX_W]);
        if (k >= `SOC_N_INIT || exp_q[t * `SOC_N_INIT + k].size() == 0)
          report_mismatch($sformatf("unexpected item at target %0d, id %h", t, tgt_id[t]));
        if (owed[t] >= `SOC_CREDITS)
          report_mismatch($sformatf("target %0d got an item beyond its credits", t));
        exp = exp_q[t * `SOC_N_INIT + k].pop_front();
        check_addr(tgt_addr[t], exp.addr, $sformatf("target %0d", t));
        check_data(tgt_data[t], exp.data, $sformatf("target %0d", t));
        check_id(tgt_id[t], exp.id, $sformatf("target %0d", t));
        owed[t]++;
      end
      // Return a credit after a random delay
      tgt_credit[t] <= 1'b0;
      if (owed[t] > 0 && delay[t] == 0) begin
        tgt_credit[t] <= 1'b1;
        owed[t]--;
        delay[t] = $urandom % 6;
      end else if (delay[t] > 0) begin
        delay[t]--;
      end
    end
    for (int i = 0; i < `SOC_N_INIT; i++) begin
      if (init_credit[i]) init_cred[i]++;
      if (decode_err[i]) begin
        if (err_pend[i] == 0)
          report_mismatch($sformatf("unexpected decode error on initiator %0d", i));
        err_pend[i]--;
      end
      init_valid[i] <= 1'b0;
      if (sent < num_req && init_cred[i] > 0 && $urandom % 3 != 0) begin
        exp.addr = pick_addr();
        exp.data = $urandom;
        exp.id   = {init_idx_t'(i), id_in_t'($urandom % 16)};
        tgt      = map_addr(exp.addr);
        if (tgt < 0) err_pend[i]++;
        else exp_q[tgt * `SOC_N_INIT + i].push_back(exp);
        init_valid[i] <= 1'b1;
        init_addr[i]  <= exp.addr;
        init_data[i]  <= exp.data;
        init_id[i]    <= exp.id[`SOC_ID_IN_W-1:0];
        init_cred[i]--;
        sent++;
      end
    end
  endtask

  function automatic bit drained();
    foreach (exp_q[p]) if (exp_q[p].size() != 0) return 1'b0;
    foreach (err_pend[i]) if (err_pend[i] != 0) return 1'b0;
    foreach (owed[t]) if (owed[t] != 0) return 1'b0;
    return 1'b1;
  endfunction

  initial begin
    int cycles;
    void'($urandom(32'h3bab_1c8d));
    arst_n     = 1'b0;
    init_valid = '0;
    init_addr  = '0;
    init_data  = '0;
    init_id    = '0;
    tgt_credit = '0;
    sent       = 0;
    foreach (init_cred[i]) init_cred[i] = `SOC_CREDITS;
    foreach (err_pend[i]) err_pend[i] = 0;
    foreach (owed[t]) owed[t] = 0;
    foreach (delay[t]) delay[t] = 0;
    repeat (10) @(posedge clk_i);
    arst_n <= 1'b1;
    check_count(credit_cnt_t'(|{tgt_valid, init_credit, decode_err}), '0, "active outputs");
    for (int t = 0; t < `SOC_N_TGT; t++)
      check_count(UUT.i_egress.credits[t], `SOC_CREDITS, $sformatf("reset credits %0d", t));
    cycles = 0;
    while (sent < num_req) begin
      @(posedge clk_i);
      step_cycle();
      cycles++;
      if (cycles > send_timeout) abort_run("Timeout: initiators could not send all requests");
    end
    cycles = 0;
    while (!drained()) begin
      @(posedge clk_i);
      step_cycle();
      cycles++;
      if (cycles > drain_limit) abort_run("Timeout: traffic did not drain from the bus");
    end
    // Last returned target credit reaches the egress one edge later
    repeat (2) begin
      @(posedge clk_i);
      step_cycle();
    end
    for (int i = 0; i < `SOC_N_INIT; i++)
      check_count(credit_cnt_t'(init_cred[i]), `SOC_CREDITS, $sformatf("initiator %0d", i));
    for (int t = 0; t < `SOC_N_TGT; t++)
      check_count(UUT.i_egress.credits[t], `SOC_CREDITS, $sformatf("egress credits %0d", t));
    $display("No errors");
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/soc_bus_pkg.sv
verilog/soc_bus_if.sv
verilog/soc_bus_ingress.sv
verilog/soc_bus_switch.sv
verilog/soc_bus_egress.sv
verilog/soc_bus.sv
verif/soc_bus_assert.sv
verif/soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/soc_bus_pkg.sv
      - verilog/soc_bus_if.sv
      - verilog/soc_bus_ingress.sv
      - verilog/soc_bus_switch.sv
      - verilog/soc_bus_egress.sv
      - verilog/soc_bus.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/soc_bus_assert.sv
      - verif/soc_bus_tb.sv
